// ==== Bender.yml ====
package:
  name: execute_stage

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/exe_pkg.sv
      - hw/exe_operand_if.sv
      - hw/stage_reg.sv
      - hw/operand_forward.sv
      - hw/alu_unit.sv
      - hw/mul_unit.sv
      - hw/execute_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - test/exe_checker.sv
      - test/tb_execute.sv

// ==== files.f ====
+incdir+hw
hw/exe_pkg.sv
hw/exe_operand_if.sv
hw/stage_reg.sv
hw/operand_forward.sv
hw/alu_unit.sv
hw/mul_unit.sv
hw/execute_top.sv
test/exe_checker.sv
test/tb_execute.sv

// ==== hw/alu_unit.sv ====
// ================================================
// Base RV32I ALU with comparator
// Result is combinational from the resolved operands
// Branch decision comes from the comparator flags
// ================================================

`include "exe_settings.svh"

module alu_unit import exe_pkg::*; (
    exe_operand_if.dst        opnd,
    input  alu_op_e           alu_op_i,
    input  br_op_e            br_op_i,
    input  cmp_sel_e          cmp_sel_i,
    input  logic [`XLEN-1:0]  imm_i,
    output logic [`XLEN-1:0]  alu_result_o,
    output logic              branch_taken_o
);

    logic [`XLEN-1:0] adder_out;
    logic [4:0]       shamt;
    logic [`XLEN-1:0] cmp_opr2;
    logic [`XLEN:0]   cmp_diff;
    logic             cmp_zero;
    logic             cmp_neg;
    logic             cmp_ovf;
    logic             cmp_carry;
    logic             cmp_lt;

    // Shared adder, subtracts for anything but ADD
    assign adder_out = (alu_op_i == ALU_ADD) ? (opnd.opr1 + opnd.opr2)
                                             : (opnd.opr1 - opnd.opr2);

    // Shift amount from operand 2
    assign shamt = opnd.opr2[4:0];

    // Comparator works on rs1 against rs2 or imm
    assign cmp_opr2 = (cmp_sel_i == CMP_IMM) ? imm_i : opnd.rs2_val;

    // One extra bit keeps the borrow as carry flag
    assign cmp_diff  = {1'b0, opnd.rs1_val} - {1'b0, cmp_opr2};
    assign cmp_zero  = ~(|cmp_diff[`XLEN-1:0]);
    assign cmp_neg   = cmp_diff[`XLEN-1];
    assign cmp_carry = cmp_diff[`XLEN];

    // Signed overflow when operand signs differ and the result flips
    assign cmp_ovf = (cmp_neg & ~opnd.rs1_val[`XLEN-1] & cmp_opr2[`XLEN-1])
                   | (~cmp_neg & opnd.rs1_val[`XLEN-1] & ~cmp_opr2[`XLEN-1]);

    // Signed less than
    assign cmp_lt = cmp_neg ^ cmp_ovf;

    // Branch condition
    always_comb begin
        case (br_op_i)
            BR_EQ:   branch_taken_o = cmp_zero;
            BR_NE:   branch_taken_o = ~cmp_zero;
            BR_LT:   branch_taken_o = cmp_lt;
            BR_GE:   branch_taken_o = ~cmp_lt;
            BR_LTU:  branch_taken_o = cmp_carry;
            BR_GEU:  branch_taken_o = ~cmp_carry;
            default: branch_taken_o = 1'b0;
        endcase
    end

    // Result mux
    always_comb begin
        case (alu_op_i)
            ALU_ADD,
            ALU_SUB:       alu_result_o = adder_out;
            ALU_AND:       alu_result_o = opnd.opr1 & opnd.opr2;
            ALU_OR:        alu_result_o = opnd.opr1 | opnd.opr2;
            ALU_XOR:       alu_result_o = opnd.opr1 ^ opnd.opr2;
            ALU_SLL:       alu_result_o = opnd.opr1 << shamt;
            ALU_SRL:       alu_result_o = opnd.opr1 >> shamt;
            ALU_SRA:       alu_result_o = $signed(opnd.opr1) >>> shamt;
            ALU_SLT:       alu_result_o = `XLEN'(cmp_lt);
            ALU_SLTU:      alu_result_o = `XLEN'(cmp_carry);
            // jal/jalr link value path
            ALU_COPY_OPR1: alu_result_o = opnd.opr1;
            // lui
            ALU_COPY_OPR2: alu_result_o = opnd.opr2;
            default:       alu_result_o = '0;
        endcase
    end

endmodule

// ==== hw/exe_operand_if.sv ====
// ================================================
// Resolved execute operands
// Driven by the forwarding block and read by the
// ALU and the multiplier, plain levels only
// ================================================

`include "exe_settings.svh"

interface exe_operand_if ();

    // Forwarded register values
    logic [`XLEN-1:0] rs1_val;
    logic [`XLEN-1:0] rs2_val;

    // ALU inputs after source selection
    logic [`XLEN-1:0] opr1;
    logic [`XLEN-1:0] opr2;

    // Forwarding side
    modport src (
        output rs1_val,
        output rs2_val,
        output opr1,
        output opr2
    );

    // Arithmetic side
    modport dst (
        input rs1_val,
        input rs2_val,
        input opr1,
        input opr2
    );

endinterface

// ==== hw/exe_pkg.sv ====
// ================================================
// Shared types for the RV32 execute stage
// Operator encodings and the payloads of the two
// pipeline registers around the stage
// Imported by the RTL and by the testbench
// ================================================

`include "exe_settings.svh"

package exe_pkg;

    // Base integer ALU operators
    typedef enum logic [3:0] {
        ALU_ADD       = 4'd0,
        ALU_SUB       = 4'd1,
        ALU_AND       = 4'd2,
        ALU_OR        = 4'd3,
        ALU_XOR       = 4'd4,
        ALU_SLL       = 4'd5,
        ALU_SRL       = 4'd6,
        ALU_SRA       = 4'd7,
        ALU_SLT       = 4'd8,
        ALU_SLTU      = 4'd9,
        ALU_COPY_OPR1 = 4'd10,
        ALU_COPY_OPR2 = 4'd11
    } alu_op_e;

    // RV32M multiply operators, anything but NONE overrides the ALU result
    typedef enum logic [2:0] {
        MUL_NONE   = 3'd0,
        MUL_MUL    = 3'd1,
        MUL_MULH   = 3'd2,
        MUL_MULHSU = 3'd3,
        MUL_MULHU  = 3'd4
    } mul_op_e;

    // Branch conditions
    typedef enum logic [2:0] {
        BR_NONE = 3'd0,
        BR_EQ   = 3'd1,
        BR_NE   = 3'd2,
        BR_LT   = 3'd3,
        BR_GE   = 3'd4,
        BR_LTU  = 3'd5,
        BR_GEU  = 3'd6
    } br_op_e;

    // ALU operand sources
    typedef enum logic {OPR1_REG = 1'b0, OPR1_PC  = 1'b1} opr1_sel_e;
    typedef enum logic {OPR2_REG = 1'b0, OPR2_IMM = 1'b1} opr2_sel_e;

    // Comparator second operand source
    typedef enum logic {CMP_REG = 1'b0, CMP_IMM = 1'b1} cmp_sel_e;

    // Decode to execute payload
    typedef struct packed {
        alu_op_e                alu_op;
        mul_op_e                mul_op;
        br_op_e                 br_op;
        opr1_sel_e              opr1_sel;
        opr2_sel_e              opr2_sel;
        cmp_sel_e               cmp_sel;
        logic                   jump;
        logic                   branch;
        logic                   rd_wr;
        logic [`RF_AWIDTH-1:0]  rd_addr;
        logic [`RF_AWIDTH-1:0]  rs1_addr;
        logic [`RF_AWIDTH-1:0]  rs2_addr;
        logic [`XLEN-1:0]       rs1_data;
        logic [`XLEN-1:0]       rs2_data;
        logic [`XLEN-1:0]       imm;
        logic [`XLEN-1:0]       pc;
    } id2exe_s;

    // Execute to load/store payload
    typedef struct packed {
        logic                   rd_wr;
        logic [`RF_AWIDTH-1:0]  rd_addr;
        logic [`XLEN-1:0]       result;
        logic [`XLEN-1:0]       store_data;
    } exe2lsu_s;

endpackage

// ==== hw/exe_settings.svh ====
// ================================================
// Width settings for the execute stage
// Included by the package, the interface and every
// RTL file that sizes a data or address bus
// ================================================

`ifndef EXE_SETTINGS_SVH
`define EXE_SETTINGS_SVH

// Integer register and datapath width
`define XLEN 32

// Register file address width
`define RF_AWIDTH 5

`endif

// ==== hw/execute_top.sv ====
// ================================================
// Execute stage of the RV32 integer pipeline
// Decode fields are registered, executed with
// forwarding and registered toward the LSU stage
// Taken branches and jumps redirect fetch and
// squash the instruction behind them
// ================================================

`include "exe_settings.svh"

module execute_top import exe_pkg::*; (
    input  logic                   clk,
    input  logic                   reset_i,

    // Decode side
    input  logic                   id_valid_i,
    input  alu_op_e                id_alu_op_i,
    input  mul_op_e                id_mul_op_i,
    input  br_op_e                 id_br_op_i,
    input  opr1_sel_e              id_opr1_sel_i,
    input  opr2_sel_e              id_opr2_sel_i,
    input  cmp_sel_e               id_cmp_sel_i,
    input  logic                   id_jump_i,
    input  logic                   id_branch_i,
    input  logic                   id_rd_wr_i,
    input  logic [`RF_AWIDTH-1:0]  id_rd_addr_i,
    input  logic [`RF_AWIDTH-1:0]  id_rs1_addr_i,
    input  logic [`RF_AWIDTH-1:0]  id_rs2_addr_i,
    input  logic [`XLEN-1:0]       id_rs1_data_i,
    input  logic [`XLEN-1:0]       id_rs2_data_i,
    input  logic [`XLEN-1:0]       id_imm_i,
    input  logic [`XLEN-1:0]       id_pc_i,

    // Writeback side
    input  logic                   wrb_wr_i,
    input  logic [`RF_AWIDTH-1:0]  wrb_rd_addr_i,
    input  logic [`XLEN-1:0]       wrb_rd_data_i,

    // Memory side
    output logic                   lsu_valid_o,
    output logic                   lsu_rd_wr_o,
    output logic [`RF_AWIDTH-1:0]  lsu_rd_addr_o,
    output logic [`XLEN-1:0]       lsu_result_o,
    output logic [`XLEN-1:0]       lsu_store_data_o,

    // Fetch side
    output logic                   new_pc_req_o,
    output logic [`XLEN-1:0]       pc_new_o
);

    id2exe_s          id_d;
    id2exe_s          exe_q;
    logic             exe_valid;
    exe2lsu_s         lsu_d;
    exe2lsu_s         lsu_q;
    logic             lsu_valid;
    logic [`XLEN-1:0] alu_result;
    logic [`XLEN-1:0] mul_result;
    logic             branch_taken;
    logic             redirect;

    exe_operand_if u_opnd_if ();

    // Pack the decode ports
    assign id_d = '{
        alu_op:   id_alu_op_i,
        mul_op:   id_mul_op_i,
        br_op:    id_br_op_i,
        opr1_sel: id_opr1_sel_i,
        opr2_sel: id_opr2_sel_i,
        cmp_sel:  id_cmp_sel_i,
        jump:     id_jump_i,
        branch:   id_branch_i,
        rd_wr:    id_rd_wr_i,
        rd_addr:  id_rd_addr_i,
        rs1_addr: id_rs1_addr_i,
        rs2_addr: id_rs2_addr_i,
        rs1_data: id_rs1_data_i,
        rs2_data: id_rs2_data_i,
        imm:      id_imm_i,
        pc:       id_pc_i
    };

    // Decode to execute, squashed behind a redirect
    stage_reg #(.payload_t(id2exe_s)) u_id2exe (
        .clk     (clk),
        .reset_i (reset_i),
        .valid_i (id_valid_i),
        .flush_i (redirect),
        .data_i  (id_d),
        .valid_o (exe_valid),
        .data_o  (exe_q)
    );

    operand_forward u_operand_forward (
        .exe_i         (exe_q),
        .lsu_valid_i   (lsu_valid),
        .lsu_i         (lsu_q),
        .wrb_wr_i      (wrb_wr_i),
        .wrb_rd_addr_i (wrb_rd_addr_i),
        .wrb_rd_data_i (wrb_rd_data_i),
        .opnd          (u_opnd_if.src)
    );

    alu_unit u_alu_unit (
        .opnd           (u_opnd_if.dst),
        .alu_op_i       (exe_q.alu_op),
        .br_op_i        (exe_q.br_op),
        .cmp_sel_i      (exe_q.cmp_sel),
        .imm_i          (exe_q.imm),
        .alu_result_o   (alu_result),
        .branch_taken_o (branch_taken)
    );

    mul_unit u_mul_unit (
        .opnd         (u_opnd_if.dst),
        .mul_op_i     (exe_q.mul_op),
        .mul_result_o (mul_result)
    );

    // Jump always redirects, a branch only when its condition holds
    assign redirect = exe_valid & (exe_q.jump | (exe_q.branch & branch_taken));

    // Multiply result replaces the ALU result
    assign lsu_d.rd_wr      = exe_q.rd_wr;
    assign lsu_d.rd_addr    = exe_q.rd_addr;
    assign lsu_d.result     = (exe_q.mul_op != MUL_NONE) ? mul_result : alu_result;
    assign lsu_d.store_data = u_opnd_if.rs2_val;

    // Execute to LSU, never flushed
    stage_reg #(.payload_t(exe2lsu_s)) u_exe2lsu (
        .clk     (clk),
        .reset_i (reset_i),
        .valid_i (exe_valid),
        .flush_i (1'b0),
        .data_i  (lsu_d),
        .valid_o (lsu_valid),
        .data_o  (lsu_q)
    );

    // LSU outputs, write request only with a valid instruction
    assign lsu_valid_o      = lsu_valid;
    assign lsu_rd_wr_o      = lsu_valid & lsu_q.rd_wr;
    assign lsu_rd_addr_o    = lsu_q.rd_addr;
    assign lsu_result_o     = lsu_q.result;
    assign lsu_store_data_o = lsu_q.store_data;

    // Target is pc plus imm from the ALU, word aligned
    assign new_pc_req_o = redirect;
    assign pc_new_o     = {alu_result[`XLEN-1:2], 2'b00};

endmodule

// ==== hw/mul_unit.sv ====
// ================================================
// RV32M multiplier, single cycle
// Operands are widened by one bit so a single
// signed multiply covers all four operators
// ================================================

`include "exe_settings.svh"

module mul_unit import exe_pkg::*; (
    exe_operand_if.dst        opnd,
    input  mul_op_e           mul_op_i,
    output logic [`XLEN-1:0]  mul_result_o
);

    logic                       opr1_signed;
    logic                       opr2_signed;
    logic signed [`XLEN:0]      mul_a;
    logic signed [`XLEN:0]      mul_b;
    logic signed [2*`XLEN-1:0]  product;

    // MULH and MULHSU take rs1 as signed
    assign opr1_signed = (mul_op_i == MUL_MULH) | (mul_op_i == MUL_MULHSU);

    // Only MULH takes rs2 as signed
    assign opr2_signed = (mul_op_i == MUL_MULH);

    // Sign or zero extend to 33 bits
    assign mul_a = {opr1_signed & opnd.opr1[`XLEN-1], opnd.opr1};
    assign mul_b = {opr2_signed & opnd.opr2[`XLEN-1], opnd.opr2};

    // Low 64 bits of the 66 bit product are exact
    assign product = mul_a * mul_b;

    // MUL keeps the low word, the rest the high word
    assign mul_result_o = (mul_op_i == MUL_MUL) ? product[`XLEN-1:0]
                                                : product[2*`XLEN-1:`XLEN];

endmodule

// ==== hw/operand_forward.sv ====
// ================================================
// Operand forwarding for the execute stage
// LSU stage result has priority over writeback
// x0 is never forwarded
// Also selects the two ALU inputs
// ================================================

`include "exe_settings.svh"

module operand_forward import exe_pkg::*; (
    input  id2exe_s                exe_i,
    input  logic                   lsu_valid_i,
    input  exe2lsu_s               lsu_i,
    input  logic                   wrb_wr_i,
    input  logic [`RF_AWIDTH-1:0]  wrb_rd_addr_i,
    input  logic [`XLEN-1:0]       wrb_rd_data_i,
    exe_operand_if.src             opnd
);

    logic lsu_fwd_ok;
    logic wrb_fwd_ok;
    logic rs1_lsu_hit;
    logic rs1_wrb_hit;
    logic rs2_lsu_hit;
    logic rs2_wrb_hit;

    // A source can forward only if it writes a nonzero rd
    assign lsu_fwd_ok = lsu_valid_i & lsu_i.rd_wr & (|lsu_i.rd_addr);
    assign wrb_fwd_ok = wrb_wr_i & (|wrb_rd_addr_i);

    // Address matches per source register
    assign rs1_lsu_hit = lsu_fwd_ok & (lsu_i.rd_addr == exe_i.rs1_addr);
    assign rs1_wrb_hit = wrb_fwd_ok & (wrb_rd_addr_i == exe_i.rs1_addr);
    assign rs2_lsu_hit = lsu_fwd_ok & (lsu_i.rd_addr == exe_i.rs2_addr);
    assign rs2_wrb_hit = wrb_fwd_ok & (wrb_rd_addr_i == exe_i.rs2_addr);

    // Youngest producer wins
    assign opnd.rs1_val = rs1_lsu_hit ? lsu_i.result
                        : rs1_wrb_hit ? wrb_rd_data_i
                        : exe_i.rs1_data;

    assign opnd.rs2_val = rs2_lsu_hit ? lsu_i.result
                        : rs2_wrb_hit ? wrb_rd_data_i
                        : exe_i.rs2_data;

    // Operand 1 is pc for auipc, jal and branch targets
    assign opnd.opr1 = (exe_i.opr1_sel == OPR1_PC) ? exe_i.pc : opnd.rs1_val;

    // Operand 2 is the immediate for I/U type and target math
    assign opnd.opr2 = (exe_i.opr2_sel == OPR2_IMM) ? exe_i.imm : opnd.rs2_val;

endmodule

// ==== hw/stage_reg.sv ====
// ================================================
// Generic pipeline register with a valid bit
// The payload type is set per instance
// Flush drops the incoming valid for one edge
// ================================================

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset_i,
    input  logic     valid_i,
    input  logic     flush_i,
    input  payload_t data_i,
    output logic     valid_o,
    output payload_t data_o
);

    // Valid bit, cleared on reset and on flush
    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i & ~flush_i;
        end
    end

    // Payload loads every cycle and is only meaningful with valid
    always_ff @(posedge clk) begin
        data_o <= data_i;
    end

endmodule

// ==== test/exe_checker.sv ====
// ================================================
// Checker for the execute stage outputs
// Keeps the expected LSU items in issue order and
// compares LSU outputs and redirects at the
// falling edge, where all DUT outputs are settled
// ================================================

`include "exe_settings.svh"

module exe_checker import exe_pkg::*; (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic                   lsu_valid_i,
    input  logic                   lsu_rd_wr_i,
    input  logic [`RF_AWIDTH-1:0]  lsu_rd_addr_i,
    input  logic [`XLEN-1:0]       lsu_result_i,
    input  logic [`XLEN-1:0]       lsu_store_data_i,
    input  logic                   new_pc_req_i,
    input  logic [`XLEN-1:0]       pc_new_i,
    input  logic                   push_i,
    input  exe2lsu_s               push_item_i,
    input  logic                   exp_redirect_i,
    input  logic [`XLEN-1:0]       exp_pc_i,
    output int                     mismatch_count_o,
    output int                     failure_count_o,
    output int                     pending_o
);

    // Expected LSU items, oldest first
    exe2lsu_s exp_q[$];
    int       mismatch_cnt = 0;
    int       failure_cnt = 0;
    int       pending = 0;

    assign mismatch_count_o = mismatch_cnt;
    assign failure_count_o  = failure_cnt;
    assign pending_o        = pending;

    always @(negedge clk) begin
        exe2lsu_s expected;
        if (!reset_i) begin
            // Items queued in an earlier cycle are due now
            if (lsu_valid_i === 1'b1) begin
                if (exp_q.size() == 0) begin
                    $display("Error at %0t: LSU output valid but no instruction was expected",
                             $time);
                    failure_cnt++;
                end else begin
                    expected = exp_q.pop_front();
                    if (lsu_rd_wr_i !== expected.rd_wr || lsu_rd_addr_i !== expected.rd_addr
                        || lsu_result_i !== expected.result
                        || lsu_store_data_i !== expected.store_data) begin
                        $display("Mismatch at %0t: LSU wr %b rd %0d res %h st %h, exp %b %0d %h %h",
                                 $time, lsu_rd_wr_i, lsu_rd_addr_i, lsu_result_i,
                                 lsu_store_data_i, expected.rd_wr, expected.rd_addr,
                                 expected.result, expected.store_data);
                        mismatch_cnt++;
                    end
                end
            end else begin
                // Empty stage, no write request allowed
                if (lsu_valid_i !== 1'b0 || lsu_rd_wr_i !== 1'b0) begin
                    $display("Mismatch at %0t: idle LSU outputs show valid %b write %b",
                             $time, lsu_valid_i, lsu_rd_wr_i);
                    mismatch_cnt++;
                end
                if (exp_q.size() != 0) begin
                    $display("Error at %0t: an instruction did not reach the LSU outputs on time",
                             $time);
                    failure_cnt++;
                    exp_q.delete(0);
                end
            end
            // Redirect belongs to the instruction now in execute
            if (new_pc_req_i !== exp_redirect_i) begin
                $display("Mismatch at %0t: new_pc_req_o is %b, expected %b",
                         $time, new_pc_req_i, exp_redirect_i);
                mismatch_cnt++;
            end else if (exp_redirect_i && pc_new_i !== exp_pc_i) begin
                $display("Mismatch at %0t: pc_new_o is %h, expected %h",
                         $time, pc_new_i, exp_pc_i);
                mismatch_cnt++;
            end
            // Executing instruction shows up one cycle later
            if (push_i) begin
                exp_q.push_back(push_item_i);
            end
            pending = exp_q.size();
        end
    end

endmodule

// ==== test/tb_execute.sv ====
// ================================================
// Testbench for the RV32 execute stage
// Random decode stream and writeback traffic, with a
// shadow pipeline that forwards, squashes and
// predicts every LSU item and fetch redirect
// ================================================

`include "exe_settings.svh"

module tb_execute import exe_pkg::*; ();

    localparam int NUM_ISSUE   = 4000;
    localparam int DRAIN_LIMIT = 20;

    // Reference model outputs
    typedef struct packed {
        logic [`XLEN-1:0] result;
        logic             taken;
        logic [`XLEN-1:0] target;
    } model_out_t;

    logic                   clk;
    logic                   reset_i;
    logic                   id_valid;
    id2exe_s                cur_id;
    logic                   wrb_wr;
    logic [`RF_AWIDTH-1:0]  wrb_rd_addr;
    logic [`XLEN-1:0]       wrb_rd_data;

    // DUT outputs
    logic                   lsu_valid;
    logic                   lsu_rd_wr;
    logic [`RF_AWIDTH-1:0]  lsu_rd_addr;
    logic [`XLEN-1:0]       lsu_result;
    logic [`XLEN-1:0]       lsu_store_data;
    logic                   new_pc_req;
    logic [`XLEN-1:0]       pc_new;

    // Shadow pipeline with an execute entry and an LSU entry
    logic                   sh_ex_valid;
    id2exe_s                sh_ex;
    exe2lsu_s               sh_ex_out;
    logic                   sh_lsu_valid;
    exe2lsu_s               sh_lsu;

    // Expectations for the checker
    logic                   push_valid;
    exe2lsu_s               push_item;
    logic                   exp_redirect;
    logic [`XLEN-1:0]       exp_pc;

    int                     mismatch_count;
    int                     failure_count;
    int                     pending;
    int                     cyc;
    int                     wait_cnt;
    logic                   timed_out;

    initial clk = 1'b0;
    always #4 clk = ~clk;

    execute_top u_execute_top (
        .clk              (clk),
        .reset_i          (reset_i),
        .id_valid_i       (id_valid),
        .id_alu_op_i      (cur_id.alu_op),
        .id_mul_op_i      (cur_id.mul_op),
        .id_br_op_i       (cur_id.br_op),
        .id_opr1_sel_i    (cur_id.opr1_sel),
        .id_opr2_sel_i    (cur_id.opr2_sel),
        .id_cmp_sel_i     (cur_id.cmp_sel),
        .id_jump_i        (cur_id.jump),
        .id_branch_i      (cur_id.branch),
        .id_rd_wr_i       (cur_id.rd_wr),
        .id_rd_addr_i     (cur_id.rd_addr),
        .id_rs1_addr_i    (cur_id.rs1_addr),
        .id_rs2_addr_i    (cur_id.rs2_addr),
        .id_rs1_data_i    (cur_id.rs1_data),
        .id_rs2_data_i    (cur_id.rs2_data),
        .id_imm_i         (cur_id.imm),
        .id_pc_i          (cur_id.pc),
        .wrb_wr_i         (wrb_wr),
        .wrb_rd_addr_i    (wrb_rd_addr),
        .wrb_rd_data_i    (wrb_rd_data),
        .lsu_valid_o      (lsu_valid),
        .lsu_rd_wr_o      (lsu_rd_wr),
        .lsu_rd_addr_o    (lsu_rd_addr),
        .lsu_result_o     (lsu_result),
        .lsu_store_data_o (lsu_store_data),
        .new_pc_req_o     (new_pc_req),
        .pc_new_o         (pc_new)
    );

    exe_checker u_exe_checker (
        .clk              (clk),
        .reset_i          (reset_i),
        .lsu_valid_i      (lsu_valid),
        .lsu_rd_wr_i      (lsu_rd_wr),
        .lsu_rd_addr_i    (lsu_rd_addr),
        .lsu_result_i     (lsu_result),
        .lsu_store_data_i (lsu_store_data),
        .new_pc_req_i     (new_pc_req),
        .pc_new_i         (pc_new),
        .push_i           (push_valid),
        .push_item_i      (push_item),
        .exp_redirect_i   (exp_redirect),
        .exp_pc_i         (exp_pc),
        .mismatch_count_o (mismatch_count),
        .failure_count_o  (failure_count),
        .pending_o        (pending)
    );

    // Corner values such as the most negative number show up often
    function automatic logic [`XLEN-1:0] pick_data();
        case ($urandom_range(0, 5))
            0:       return 32'h8000_0000;
            1:       return 32'hffff_ffff;
            2:       return '0;
            3:       return $urandom_range(0, 40);
            default: return $urandom;
        endcase
    endfunction

    // LSU stage has priority over writeback and x0 is never forwarded
    function automatic logic [`XLEN-1:0] forward_operand(input logic [`RF_AWIDTH-1:0] addr,
                                                         input logic [`XLEN-1:0] data);
        if (sh_lsu_valid && sh_lsu.rd_wr && addr != 0 && sh_lsu.rd_addr == addr) begin
            return sh_lsu.result;
        end
        if (wrb_wr && addr != 0 && wrb_rd_addr == addr) begin
            return wrb_rd_data;
        end
        return data;
    endfunction

    // Result, branch decision and target from the fields and resolved operands
    function automatic model_out_t exe_model(input id2exe_s ins,
                                             input logic [`XLEN-1:0] rs1,
                                             input logic [`XLEN-1:0] rs2);
        logic [`XLEN-1:0]   a;
        logic [`XLEN-1:0]   b;
        logic [`XLEN-1:0]   c2;
        logic [`XLEN-1:0]   alu;
        logic [2*`XLEN-1:0] wa;
        logic [2*`XLEN-1:0] wb;
        logic [2*`XLEN-1:0] prod;
        model_out_t         mo;
        a  = (ins.opr1_sel == OPR1_PC) ? ins.pc : rs1;
        b  = (ins.opr2_sel == OPR2_IMM) ? ins.imm : rs2;
        // Comparisons always use rs1 against rs2 or imm
        c2 = (ins.cmp_sel == CMP_IMM) ? ins.imm : rs2;
        case (ins.alu_op)
            ALU_ADD:       alu = a + b;
            ALU_SUB:       alu = a - b;
            ALU_AND:       alu = a & b;
            ALU_OR:        alu = a | b;
            ALU_XOR:       alu = a ^ b;
            ALU_SLL:       alu = a << b[4:0];
            ALU_SRL:       alu = a >> b[4:0];
            ALU_SRA:       alu = $signed(a) >>> b[4:0];
            ALU_SLT:       alu = ($signed(rs1) < $signed(c2)) ? 1 : 0;
            ALU_SLTU:      alu = (rs1 < c2) ? 1 : 0;
            ALU_COPY_OPR1: alu = a;
            ALU_COPY_OPR2: alu = b;
            default:       alu = '0;
        endcase
        mo.result = alu;
        // Full 64 bit product where the extension picks the signedness
        if (ins.mul_op != MUL_NONE) begin
            wa = (ins.mul_op == MUL_MULH || ins.mul_op == MUL_MULHSU)
               ? {{`XLEN{a[`XLEN-1]}}, a} : {{`XLEN{1'b0}}, a};
            wb = (ins.mul_op == MUL_MULH) ? {{`XLEN{b[`XLEN-1]}}, b} : {{`XLEN{1'b0}}, b};
            prod = wa * wb;
            mo.result = (ins.mul_op == MUL_MUL) ? prod[`XLEN-1:0] : prod[2*`XLEN-1:`XLEN];
        end
        case (ins.br_op)
            BR_EQ:   mo.taken = (rs1 == c2);
            BR_NE:   mo.taken = (rs1 != c2);
            BR_LT:   mo.taken = ($signed(rs1) < $signed(c2));
            BR_GE:   mo.taken = ($signed(rs1) >= $signed(c2));
            BR_LTU:  mo.taken = (rs1 < c2);
            BR_GEU:  mo.taken = (rs1 >= c2);
            default: mo.taken = 1'b0;
        endcase
        // Word aligned pc plus imm
        mo.target = alu & ~32'h3;
        return mo;
    endfunction

    // Edge behavior of both pipeline registers including the squash
    task automatic advance_shadow();
        sh_lsu_valid = sh_ex_valid;
        sh_lsu       = sh_ex_out;
        sh_ex_valid  = id_valid & ~exp_redirect;
        sh_ex        = cur_id;
    endtask

    // One random decode slot and writeback slot
    task automatic drive_stimulus(input logic issue);
        int kind;
        kind     = $urandom_range(0, 9);
        id_valid = issue & ($urandom_range(0, 7) != 0);
        // Zero fields give a register ADD without multiply or branch
        cur_id          = '0;
        cur_id.rd_wr    = 1'b1;
        // Few registers so dependencies and x0 come up often
        cur_id.rd_addr  = $urandom_range(0, 3);
        cur_id.rs1_addr = $urandom_range(0, 3);
        cur_id.rs2_addr = $urandom_range(0, 3);
        cur_id.rs1_data = pick_data();
        cur_id.rs2_data = pick_data();
        cur_id.imm      = pick_data();
        cur_id.pc       = $urandom & 32'hffff_fffc;
        case (kind)
            0, 1, 2, 3: cur_id.alu_op = alu_op_e'($urandom_range(0, 11));
            4, 5: begin
                // Immediate forms that are sometimes pc relative
                cur_id.alu_op   = alu_op_e'($urandom_range(0, 11));
                cur_id.opr1_sel = opr1_sel_e'($urandom_range(0, 1));
                cur_id.opr2_sel = OPR2_IMM;
                cur_id.cmp_sel  = CMP_IMM;
            end
            6, 7: cur_id.mul_op = mul_op_e'($urandom_range(1, 4));
            8: begin
                cur_id.branch   = 1'b1;
                cur_id.br_op    = br_op_e'($urandom_range(1, 6));
                cur_id.cmp_sel  = cmp_sel_e'($urandom_range(0, 1));
                cur_id.opr1_sel = OPR1_PC;
                cur_id.opr2_sel = OPR2_IMM;
                cur_id.rd_wr    = 1'b0;
            end
            default: begin
                // jal or jalr style target
                cur_id.jump     = 1'b1;
                cur_id.opr1_sel = opr1_sel_e'($urandom_range(0, 1));
                cur_id.opr2_sel = OPR2_IMM;
            end
        endcase
        wrb_wr      = $urandom_range(0, 1);
        wrb_rd_addr = $urandom_range(0, 3);
        wrb_rd_data = $urandom;
    endtask

    // Expected redirect now and LSU item for the next cycle
    task automatic predict_execute();
        logic [`XLEN-1:0] rs1;
        logic [`XLEN-1:0] rs2;
        model_out_t       mo;
        rs1 = forward_operand(sh_ex.rs1_addr, sh_ex.rs1_data);
        rs2 = forward_operand(sh_ex.rs2_addr, sh_ex.rs2_data);
        mo  = exe_model(sh_ex, rs1, rs2);
        exp_redirect         = sh_ex_valid & (sh_ex.jump | (sh_ex.branch & mo.taken));
        exp_pc               = mo.target;
        sh_ex_out.rd_wr      = sh_ex.rd_wr;
        sh_ex_out.rd_addr    = sh_ex.rd_addr;
        sh_ex_out.result     = mo.result;
        sh_ex_out.store_data = rs2;
        push_valid           = sh_ex_valid;
        push_item            = sh_ex_out;
    endtask

    initial begin
        void'($urandom(32'hb415));
        reset_i      = 1'b1;
        id_valid     = 1'b0;
        cur_id       = '0;
        wrb_wr       = 1'b0;
        wrb_rd_addr  = '0;
        wrb_rd_data  = '0;
        sh_ex_valid  = 1'b0;
        sh_ex        = '0;
        sh_ex_out    = '0;
        sh_lsu_valid = 1'b0;
        sh_lsu       = '0;
        push_valid   = 1'b0;
        push_item    = '0;
        exp_redirect = 1'b0;
        exp_pc       = '0;
        timed_out    = 1'b0;

        repeat (3) @(posedge clk);
        #1 reset_i = 1'b0;

        // Last few cycles issue nothing so the pipe empties
        for (cyc = 0; cyc < NUM_ISSUE + 3; cyc++) begin
            @(posedge clk);
            advance_shadow();
            #1;
            drive_stimulus(cyc < NUM_ISSUE);
            predict_execute();
        end

        wait_cnt = 0;
        while (pending != 0 && wait_cnt < DRAIN_LIMIT) begin
            @(posedge clk);
            wait_cnt++;
        end
        if (pending != 0) begin
            $display("Timeout: %0d expected instructions never reached the LSU outputs",
                     pending);
            timed_out = 1'b1;
        end

        $display("Errors: %0d mismatches, %0d other failures, %0d left over",
                 mismatch_count, failure_count, pending);
        if (mismatch_count == 0 && failure_count == 0 && !timed_out) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule
